// ==== hw/rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Register files
`define ARCH_REG_NUM 32
`define PHY_REG_NUM 64
`define PHY_REG_SEL 6
`define FREE_TAG_NUM 32

// Flow control
`define FETCH_BUF_DEPTH 2
`define OUT_CREDIT_INIT 4

`define INSN_LEN 32

`endif

// ==== hw/rename_pkg.sv ====
package rename_pkg;

`include "rename_params.svh"

    typedef logic [`PHY_REG_SEL-1:0] phys_tag_t;
    typedef logic [$clog2(`ARCH_REG_NUM)-1:0] arch_reg_t;
    typedef logic [`INSN_LEN-1:0] insn_t;

    // Major opcodes, insn[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } rv_opcode_e;

    typedef enum logic [2:0] {
        CLASS_NONE    = 3'd0,
        CLASS_ALU     = 3'd1,
        CLASS_BRANCH  = 3'd2,
        CLASS_LDST    = 3'd3,
        CLASS_ILLEGAL = 3'd4
    } insn_class_e;

endpackage

// ==== hw/fetch_buffer.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

module fetch_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  rename_pkg::insn_t in_insn_1,
    input  rename_pkg::insn_t in_insn_2,
    input  logic              in_insn_2_valid,
    input  logic              pop,
    output logic              head_valid,
    output rename_pkg::insn_t head_insn_1,
    output rename_pkg::insn_t head_insn_2,
    output logic              head_insn_2_valid,
    output logic              in_credit
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`FETCH_BUF_DEPTH);

    insn_t            insn_1_mem [`FETCH_BUF_DEPTH];
    insn_t            insn_2_mem [`FETCH_BUF_DEPTH];
    logic             insn_2_valid_mem [`FETCH_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    assign head_valid = (count != '0);
    assign do_pop = pop && head_valid;
    assign head_insn_1 = insn_1_mem[rd_ptr];
    assign head_insn_2 = insn_2_mem[rd_ptr];
    // Slot 2 only counts when a bundle is actually at the head
    assign head_insn_2_valid = head_valid && insn_2_valid_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            insn_1_mem[wr_ptr] <= in_insn_1;
            insn_2_mem[wr_ptr] <= in_insn_2;
            insn_2_valid_mem[wr_ptr] <= in_insn_2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(in_valid) - (PTR_W+1)'(do_pop);
            // One credit back upstream per bundle that leaves
            in_credit <= do_pop;
        end
    end

    // Upstream pushes only while it holds a credit
    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (count < `FETCH_BUF_DEPTH))
        else $error("fetch_buffer: push into full buffer");

endmodule

// ==== hw/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
    input  rename_pkg::insn_t       insn,
    input  logic                    insn_valid,
    output rename_pkg::arch_reg_t   rs1,
    output rename_pkg::arch_reg_t   rs2,
    output rename_pkg::arch_reg_t   rd,
    output logic                    uses_rs1,
    output logic                    uses_rs2,
    output logic                    wr_reg,
    output rename_pkg::insn_class_e insn_class
);
    import rename_pkg::*;

    rv_opcode_e opcode;
    // rs1, rs2, rd
    logic [2:0] use_bits;

    assign opcode = rv_opcode_e'(insn[6:0]);
    assign rs1 = insn[19:15];
    assign rs2 = insn[24:20];
    assign rd = insn[11:7];

    always_comb begin
        case (opcode)
            OP:                 use_bits = 3'b111;
            OP_IMM, LOAD, JALR: use_bits = 3'b101;
            LUI, AUIPC, JAL:    use_bits = 3'b001;
            STORE, BRANCH:      use_bits = 3'b110;
            default:            use_bits = 3'b000;
        endcase
        case (opcode)
            OP, OP_IMM, LUI, AUIPC: insn_class = CLASS_ALU;
            LOAD, STORE:            insn_class = CLASS_LDST;
            BRANCH, JAL, JALR:      insn_class = CLASS_BRANCH;
            default:                insn_class = CLASS_ILLEGAL;
        endcase
        // Empty slot
        if (!insn_valid) begin
            use_bits = 3'b000;
            insn_class = CLASS_NONE;
        end
    end

    assign uses_rs1 = use_bits[2];
    assign uses_rs2 = use_bits[1];
    // Writes to x0 are dropped, so they take no tag
    assign wr_reg = use_bits[0] && (rd != '0);

endmodule

// ==== hw/phys_tag_freelist.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

module phys_tag_freelist (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               alloc_1,
    input  logic                               alloc_2,
    output rename_pkg::phys_tag_t              alloc_tag_1,
    output rename_pkg::phys_tag_t              alloc_tag_2,
    output logic [$clog2(`FREE_TAG_NUM+1)-1:0] free_count,
    input  logic                               release_valid_1,
    input  logic                               release_valid_2,
    input  rename_pkg::phys_tag_t              release_tag_1,
    input  rename_pkg::phys_tag_t              release_tag_2
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`FREE_TAG_NUM);
    localparam int CNT_W = $clog2(`FREE_TAG_NUM + 1);

    phys_tag_t        tags [`FREE_TAG_NUM];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] head_inc;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] tail_2;
    logic [1:0]       n_alloc;
    logic [1:0]       n_release;

    assign n_alloc = 2'(alloc_1) + 2'(alloc_2);
    assign n_release = 2'(release_valid_1) + 2'(release_valid_2);
    assign head_inc = head + 1'b1;
    assign tail_2 = tail + PTR_W'(release_valid_1);

    assign alloc_tag_1 = tags[head];
    // Second allocation of the cycle takes the entry after the head
    assign alloc_tag_2 = alloc_1 ? tags[head_inc] : tags[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Upper half of the register file starts free
            for (int i = 0; i < `FREE_TAG_NUM; i++) begin
                tags[i] <= phys_tag_t'(`PHY_REG_NUM - `FREE_TAG_NUM + i);
            end
            head <= '0;
            tail <= '0;
            free_count <= CNT_W'(`FREE_TAG_NUM);
        end else begin
            if (release_valid_1) begin
                tags[tail] <= release_tag_1;
            end
            if (release_valid_2) begin
                tags[tail_2] <= release_tag_2;
            end
            head <= head + PTR_W'(n_alloc);
            tail <= tail + PTR_W'(n_release);
            free_count <= free_count + CNT_W'(n_release) - CNT_W'(n_alloc);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        n_alloc <= free_count)
        else $error("phys_tag_freelist: underflow");

    // Commit returns only tags that were handed out
    assert property (@(posedge clk) disable iff (reset)
        int'(free_count) + int'(n_release) - int'(n_alloc) <= `FREE_TAG_NUM)
        else $error("phys_tag_freelist: overflow");

    assert property (@(posedge clk) disable iff (reset)
        (release_valid_1 -> release_tag_1 != '0) && (release_valid_2 -> release_tag_2 != '0))
        else $error("phys_tag_freelist: release of tag 0");

endmodule

// ==== hw/rename_map_table.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_map_table (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t rs1_1,
    input  rename_pkg::arch_reg_t rs2_1,
    input  rename_pkg::arch_reg_t rd_1,
    input  rename_pkg::arch_reg_t rs1_2,
    input  rename_pkg::arch_reg_t rs2_2,
    input  rename_pkg::arch_reg_t rd_2,
    input  logic                  wr_reg_1,
    input  logic                  wr_reg_2,
    input  rename_pkg::phys_tag_t new_dst_1,
    input  rename_pkg::phys_tag_t new_dst_2,
    input  logic                  update,
    output rename_pkg::phys_tag_t src1_1,
    output rename_pkg::phys_tag_t src2_1,
    output rename_pkg::phys_tag_t src1_2,
    output rename_pkg::phys_tag_t src2_2,
    output rename_pkg::phys_tag_t old_dst_1,
    output rename_pkg::phys_tag_t old_dst_2
);
    import rename_pkg::*;

    phys_tag_t rat [`ARCH_REG_NUM];

    assign src1_1 = rat[rs1_1];
    assign src2_1 = rat[rs2_1];
    assign old_dst_1 = rat[rd_1];

    // Slot 2 sees slot 1's new mapping within the bundle
    assign src1_2 = (wr_reg_1 && rs1_2 == rd_1) ? new_dst_1 : rat[rs1_2];
    assign src2_2 = (wr_reg_1 && rs2_2 == rd_1) ? new_dst_1 : rat[rs2_2];
    assign old_dst_2 = (wr_reg_1 && rd_2 == rd_1) ? new_dst_1 : rat[rd_2];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map, x0 on tag 0
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
        end else if (update) begin
            if (wr_reg_1) begin
                rat[rd_1] <= new_dst_1;
            end
            // Slot 2 is younger and wins on a shared rd
            if (wr_reg_2) begin
                rat[rd_2] <= new_dst_2;
            end
        end
    end

endmodule

// ==== hw/rename_output_stage.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_output_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               head_valid,
    input  logic                               need_1,
    input  logic                               need_2,
    input  logic [$clog2(`FREE_TAG_NUM+1)-1:0] free_count,
    input  logic                               out_credit,
    output logic                               fire,
    output logic                               alloc_1,
    output logic                               alloc_2,
    input  logic                               slot_valid_2,
    input  rename_pkg::insn_class_e            class_1,
    input  rename_pkg::insn_class_e            class_2,
    input  logic                               uses_rs1_1,
    input  logic                               uses_rs2_1,
    input  logic                               uses_rs1_2,
    input  logic                               uses_rs2_2,
    input  rename_pkg::phys_tag_t              src1_1,
    input  rename_pkg::phys_tag_t              src2_1,
    input  rename_pkg::phys_tag_t              src1_2,
    input  rename_pkg::phys_tag_t              src2_2,
    input  rename_pkg::phys_tag_t              dst_1,
    input  rename_pkg::phys_tag_t              dst_2,
    input  rename_pkg::phys_tag_t              old_dst_1,
    input  rename_pkg::phys_tag_t              old_dst_2,
    output logic                               out_valid,
    output logic                               out_slot_valid_2,
    output rename_pkg::insn_class_e            out_class_1,
    output rename_pkg::insn_class_e            out_class_2,
    output rename_pkg::phys_tag_t              out_src1_1,
    output rename_pkg::phys_tag_t              out_src2_1,
    output rename_pkg::phys_tag_t              out_src1_2,
    output rename_pkg::phys_tag_t              out_src2_2,
    output rename_pkg::phys_tag_t              out_dst_1,
    output rename_pkg::phys_tag_t              out_dst_2,
    output logic                               out_wr_reg_1,
    output logic                               out_wr_reg_2,
    output rename_pkg::phys_tag_t              out_old_dst_1,
    output rename_pkg::phys_tag_t              out_old_dst_2
);
    import rename_pkg::*;

    localparam int CRED_W = $clog2(`OUT_CREDIT_INIT + 1);
    // x0 mapping, never reallocated, so always ready downstream
    localparam phys_tag_t X0_TAG = '0;

    logic [CRED_W-1:0] credits;

    assign fire = head_valid && (credits != '0) && (free_count >= 2'(need_1) + 2'(need_2));
    assign alloc_1 = fire && need_1;
    assign alloc_2 = fire && need_2;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            credits <= CRED_W'(`OUT_CREDIT_INIT);
        end else begin
            out_valid <= fire;
            credits <= credits - CRED_W'(fire) + CRED_W'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_slot_valid_2 <= slot_valid_2;
            out_class_1 <= class_1;
            out_class_2 <= class_2;
            // Unused sources point at x0
            out_src1_1 <= uses_rs1_1 ? src1_1 : X0_TAG;
            out_src2_1 <= uses_rs2_1 ? src2_1 : X0_TAG;
            out_src1_2 <= uses_rs1_2 ? src1_2 : X0_TAG;
            out_src2_2 <= uses_rs2_2 ? src2_2 : X0_TAG;
            out_dst_1 <= dst_1;
            out_dst_2 <= dst_2;
            out_wr_reg_1 <= need_1;
            out_wr_reg_2 <= need_2;
            out_old_dst_1 <= old_dst_1;
            out_old_dst_2 <= old_dst_2;
        end
    end

    // Downstream never returns more credits than it was given
    assert property (@(posedge clk) disable iff (reset)
        credits <= `OUT_CREDIT_INIT)
        else $error("rename_output_stage: credit counter above initial value");

endmodule

// ==== hw/rename_unit.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

// Slot 1 always holds an instruction, so out_valid is its valid
module rename_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  rename_pkg::insn_t       in_insn_1,
    input  rename_pkg::insn_t       in_insn_2,
    input  logic                    in_insn_2_valid,
    output logic                    in_credit,
    output logic                    out_valid,
    output logic                    out_slot_valid_2,
    output rename_pkg::insn_class_e out_class_1,
    output rename_pkg::insn_class_e out_class_2,
    output rename_pkg::phys_tag_t   out_src1_1,
    output rename_pkg::phys_tag_t   out_src2_1,
    output rename_pkg::phys_tag_t   out_src1_2,
    output rename_pkg::phys_tag_t   out_src2_2,
    output rename_pkg::phys_tag_t   out_dst_1,
    output rename_pkg::phys_tag_t   out_dst_2,
    output logic                    out_wr_reg_1,
    output logic                    out_wr_reg_2,
    output rename_pkg::phys_tag_t   out_old_dst_1,
    output rename_pkg::phys_tag_t   out_old_dst_2,
    input  logic                    out_credit,
    input  logic                    com_valid_1,
    input  logic                    com_valid_2,
    input  rename_pkg::phys_tag_t   com_tag_1,
    input  rename_pkg::phys_tag_t   com_tag_2
);
    logic                               head_valid;
    rename_pkg::insn_t                  head_insn_1;
    rename_pkg::insn_t                  head_insn_2;
    logic                               head_insn_2_valid;
    logic                               fire;
    logic                               alloc_1;
    logic                               alloc_2;
    logic [$clog2(`FREE_TAG_NUM+1)-1:0] free_count;
    rename_pkg::phys_tag_t              alloc_tag_1;
    rename_pkg::phys_tag_t              alloc_tag_2;
    rename_pkg::arch_reg_t              rs1_1;
    rename_pkg::arch_reg_t              rs2_1;
    rename_pkg::arch_reg_t              rd_1;
    rename_pkg::arch_reg_t              rs1_2;
    rename_pkg::arch_reg_t              rs2_2;
    rename_pkg::arch_reg_t              rd_2;
    logic                               uses_rs1_1;
    logic                               uses_rs2_1;
    logic                               uses_rs1_2;
    logic                               uses_rs2_2;
    logic                               wr_reg_1;
    logic                               wr_reg_2;
    rename_pkg::insn_class_e            class_1;
    rename_pkg::insn_class_e            class_2;
    rename_pkg::phys_tag_t              src1_1;
    rename_pkg::phys_tag_t              src2_1;
    rename_pkg::phys_tag_t              src1_2;
    rename_pkg::phys_tag_t              src2_2;
    rename_pkg::phys_tag_t              old_dst_1;
    rename_pkg::phys_tag_t              old_dst_2;

    fetch_buffer u_fetch_buffer (.pop(fire), .*);

    insn_decoder u_dec_1 (
        .insn(head_insn_1), .insn_valid(head_valid),
        .rs1(rs1_1), .rs2(rs2_1), .rd(rd_1),
        .uses_rs1(uses_rs1_1), .uses_rs2(uses_rs2_1), .wr_reg(wr_reg_1),
        .insn_class(class_1)
    );

    insn_decoder u_dec_2 (
        .insn(head_insn_2), .insn_valid(head_insn_2_valid),
        .rs1(rs1_2), .rs2(rs2_2), .rd(rd_2),
        .uses_rs1(uses_rs1_2), .uses_rs2(uses_rs2_2), .wr_reg(wr_reg_2),
        .insn_class(class_2)
    );

    phys_tag_freelist u_freelist (
        .release_valid_1(com_valid_1), .release_valid_2(com_valid_2),
        .release_tag_1(com_tag_1), .release_tag_2(com_tag_2),
        .*
    );

    rename_map_table u_map_table (
        .new_dst_1(alloc_tag_1), .new_dst_2(alloc_tag_2), .update(fire),
        .*
    );

    rename_output_stage u_output_stage (
        .need_1(wr_reg_1), .need_2(wr_reg_2), .slot_valid_2(head_insn_2_valid),
        .dst_1(alloc_tag_1), .dst_2(alloc_tag_2),
        .*
    );

endmodule

// ==== verif/rename_unit_tb.sv ====
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_unit_tb;
    import rename_pkg::*;

    localparam int TIMEOUT = 400;

    logic        clk;
    logic        reset;
    logic        in_valid;
    insn_t       in_insn_1;
    insn_t       in_insn_2;
    logic        in_insn_2_valid;
    logic        in_credit;
    logic        out_valid;
    logic        out_slot_valid_2;
    insn_class_e out_class_1;
    insn_class_e out_class_2;
    phys_tag_t   out_src1_1;
    phys_tag_t   out_src2_1;
    phys_tag_t   out_src1_2;
    phys_tag_t   out_src2_2;
    phys_tag_t   out_dst_1;
    phys_tag_t   out_dst_2;
    logic        out_wr_reg_1;
    logic        out_wr_reg_2;
    phys_tag_t   out_old_dst_1;
    phys_tag_t   out_old_dst_2;
    logic        out_credit;
    logic        com_valid_1;
    logic        com_valid_2;
    phys_tag_t   com_tag_1;
    phys_tag_t   com_tag_2;

    // Directed bundles
    insn_t       tbl_1[$];
    insn_t       tbl_2[$];
    logic        tbl_v2[$];
    // Bundles sent and not yet seen at the output
    insn_t       exp_insn_1[$];
    insn_t       exp_insn_2[$];
    logic        exp_v2[$];
    // Reference alias table and free list
    phys_tag_t   ref_rat[`ARCH_REG_NUM];
    phys_tag_t   free_q[$];
    phys_tag_t   pending[$];

    int          errors;
    int          out_count;
    int          outstanding;
    int          up_credits;
    logic [15:0] lfsr;
    logic        flow_en;
    logic        credit_en;
    logic        release_en;
    logic        bit_credit;
    logic        bit_rel_1;
    logic        bit_rel_2;

    rename_unit dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] step_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = step_lfsr(lfsr);
        b = lfsr[0];
    endtask

    function automatic insn_t make_insn(input logic [6:0] op, input int rd, input int rs1,
                                        input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'(rd), op};
    endfunction

    task automatic add_row(input insn_t a, input insn_t b, input logic v2);
        tbl_1.push_back(a);
        tbl_2.push_back(b);
        tbl_v2.push_back(v2);
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_class(input string name, input insn_class_e got,
                               input insn_class_e exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("Run finished with %0d errors over %0d renamed bundles", errors, out_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("ERROR: timed out at %0t waiting for %s", $time, what);
        finish_run();
    endtask

    // Decode rules of the RV32 subset
    task automatic decode_ref(input insn_t insn, input logic valid, output insn_class_e cls,
                              output logic u1, output logic u2, output logic wr);
        logic urd;
        u1 = 1'b0;
        u2 = 1'b0;
        urd = 1'b0;
        cls = CLASS_ILLEGAL;
        case (insn[6:0])
            OP:          begin u1 = 1'b1; u2 = 1'b1; urd = 1'b1; cls = CLASS_ALU; end
            OP_IMM:      begin u1 = 1'b1; urd = 1'b1; cls = CLASS_ALU; end
            LUI, AUIPC:  begin urd = 1'b1; cls = CLASS_ALU; end
            LOAD:        begin u1 = 1'b1; urd = 1'b1; cls = CLASS_LDST; end
            STORE:       begin u1 = 1'b1; u2 = 1'b1; cls = CLASS_LDST; end
            BRANCH:      begin u1 = 1'b1; u2 = 1'b1; cls = CLASS_BRANCH; end
            JAL:         begin urd = 1'b1; cls = CLASS_BRANCH; end
            JALR:        begin u1 = 1'b1; urd = 1'b1; cls = CLASS_BRANCH; end
            default:     cls = CLASS_ILLEGAL;
        endcase
        if (!valid) begin
            u1 = 1'b0;
            u2 = 1'b0;
            urd = 1'b0;
            cls = CLASS_NONE;
        end
        wr = urd && (insn[11:7] != 5'd0);
    endtask

    // Slot 1 runs first, so slot 2 sees its mapping
    task automatic check_slot(input insn_t insn, input logic valid, input string sfx,
                              input phys_tag_t g_src1, input phys_tag_t g_src2,
                              input phys_tag_t g_dst, input phys_tag_t g_old,
                              input logic g_wr);
        insn_class_e cls;
        logic        u1;
        logic        u2;
        logic        wr;
        phys_tag_t   dst;
        decode_ref(insn, valid, cls, u1, u2, wr);
        check_tag({"out_src1_", sfx}, g_src1, u1 ? ref_rat[insn[19:15]] : phys_tag_t'(0));
        check_tag({"out_src2_", sfx}, g_src2, u2 ? ref_rat[insn[24:20]] : phys_tag_t'(0));
        check_bit({"out_wr_reg_", sfx}, g_wr, wr);
        if (wr) begin
            if (free_q.size() == 0) begin
                errors++;
                $display("ERROR: slot %s renamed at %0t with no free tag left", sfx, $time);
            end else begin
                dst = free_q.pop_front();
                check_tag({"out_dst_", sfx}, g_dst, dst);
                check_tag({"out_old_dst_", sfx}, g_old, ref_rat[insn[11:7]]);
                pending.push_back(ref_rat[insn[11:7]]);
                ref_rat[insn[11:7]] = dst;
            end
        end
    endtask

    task automatic check_bundle;
        insn_t       a;
        insn_t       b;
        logic        v2;
        insn_class_e ca;
        insn_class_e cb;
        logic        u1;
        logic        u2;
        logic        wr;
        if (exp_insn_1.size() == 0) begin
            errors++;
            $display("ERROR: out_valid at %0t with no bundle outstanding", $time);
            return;
        end
        a = exp_insn_1.pop_front();
        b = exp_insn_2.pop_front();
        v2 = exp_v2.pop_front();
        decode_ref(a, 1'b1, ca, u1, u2, wr);
        decode_ref(b, v2, cb, u1, u2, wr);
        check_bit("out_slot_valid_2", out_slot_valid_2, v2);
        check_class("out_class_1", out_class_1, ca);
        check_class("out_class_2", out_class_2, cb);
        check_slot(a, 1'b1, "1", out_src1_1, out_src2_1, out_dst_1, out_old_dst_1,
                   out_wr_reg_1);
        check_slot(b, v2, "2", out_src1_2, out_src2_2, out_dst_2, out_old_dst_2,
                   out_wr_reg_2);
    endtask

    task automatic push_bundle(input insn_t a, input insn_t b, input logic v2);
        int waited;
        waited = 0;
        while (up_credits == 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort("an upstream credit");
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_insn_1 = a;
        in_insn_2 = b;
        in_insn_2_valid = v2;
        up_credits--;
        exp_insn_1.push_back(a);
        exp_insn_2.push_back(b);
        exp_v2.push_back(v2);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int left, input string what);
        int waited;
        waited = 0;
        while (exp_insn_1.size() > left) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort(what);
        end
    endtask

    // Downstream credit return and commit releases
    always @(posedge clk) begin
        #1;
        draw_bit(bit_credit);
        draw_bit(bit_rel_1);
        draw_bit(bit_rel_2);
        out_credit = flow_en && credit_en && (outstanding > 0) && bit_credit;
        if (out_credit) outstanding--;
        com_valid_1 = flow_en && release_en && (pending.size() > 0) && bit_rel_1;
        if (com_valid_1) begin
            com_tag_1 = pending.pop_front();
            free_q.push_back(com_tag_1);
        end
        com_valid_2 = flow_en && release_en && (pending.size() > 0) && bit_rel_2;
        if (com_valid_2) begin
            com_tag_2 = pending.pop_front();
            free_q.push_back(com_tag_2);
        end
    end

    always @(negedge clk) begin
        if (in_credit === 1'b1) up_credits++;
        if (out_valid === 1'b1) begin
            out_count++;
            outstanding++;
            check_bundle();
        end
    end

    initial begin
        int n;
        int base;
        int waited;
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_insn_1 = '0;
        in_insn_2 = '0;
        in_insn_2_valid = 1'b0;
        out_credit = 1'b0;
        com_valid_1 = 1'b0;
        com_valid_2 = 1'b0;
        com_tag_1 = '0;
        com_tag_2 = '0;
        errors = 0;
        out_count = 0;
        outstanding = 0;
        up_credits = `FETCH_BUF_DEPTH;
        lfsr = 16'd65186;
        flow_en = 1'b0;
        credit_en = 1'b1;
        release_en = 1'b1;
        for (int i = 0; i < `ARCH_REG_NUM; i++) ref_rat[i] = phys_tag_t'(i);
        for (int i = 0; i < `FREE_TAG_NUM; i++) free_q.push_back(phys_tag_t'(32 + i));

        // Bypass, same rd in both slots, no-alloc classes, x0 writes
        add_row(make_insn(OP, 1, 2, 3), make_insn(OP_IMM, 4, 1, 0), 1'b1);
        add_row(make_insn(OP, 5, 1, 4), make_insn(OP, 5, 5, 5), 1'b1);
        add_row(make_insn(OP, 6, 5, 0), make_insn(7'h7f, 9, 1, 2), 1'b1);
        add_row(make_insn(STORE, 0, 5, 6), make_insn(BRANCH, 0, 1, 4), 1'b1);
        add_row(make_insn(LUI, 0, 0, 0), make_insn(JAL, 7, 0, 0), 1'b1);
        add_row(make_insn(LOAD, 8, 7, 0), make_insn(JALR, 9, 8, 0), 1'b1);
        add_row(make_insn(AUIPC, 10, 0, 0), make_insn(OP, 3, 3, 3), 1'b0);
        add_row(make_insn(OP, 0, 1, 2), make_insn(OP_IMM, 11, 10, 0), 1'b1);

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        flow_en = 1'b1;

        for (int i = 0; i < tbl_1.size(); i++) push_bundle(tbl_1[i], tbl_2[i], tbl_v2[i]);
        wait_outputs(0, "the directed bundles");

        // Credit stall
        waited = 0;
        while (outstanding != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort("downstream credits to return");
        end
        credit_en = 1'b0;
        base = out_count;
        for (int i = 0; i < 6; i++) push_bundle(make_insn(OP_IMM, 12 + i, 1, 0), '0, 1'b0);
        repeat (20) @(negedge clk);
        if (out_count - base != `OUT_CREDIT_INIT || exp_insn_1.size() != 2) begin
            errors++;
            $display("ERROR: %0d bundles left without credits", out_count - base);
        end
        if (up_credits != 0) begin
            errors++;
            $display("ERROR: upstream credit returned while the buffer was stalled");
        end
        credit_en = 1'b1;
        wait_outputs(0, "bundles after credits resumed");

        // Free list exhaustion
        release_en = 1'b0;
        n = free_q.size();
        for (int i = 0; n > 0; i++) begin
            push_bundle(make_insn(OP, (i % 15) * 2 + 1, 2, 3),
                        make_insn(OP_IMM, (i % 15) * 2 + 2, (i % 15) * 2 + 1, 0), n > 1);
            n -= 2;
        end
        push_bundle(make_insn(OP, 20, 21, 22), make_insn(OP_IMM, 21, 20, 0), 1'b1);
        push_bundle(make_insn(LUI, 22, 0, 0), make_insn(OP, 23, 22, 21), 1'b1);
        wait_outputs(2, "the free list to run out");
        base = out_count;
        repeat (20) @(negedge clk);
        if (out_count != base || exp_insn_1.size() != 2) begin
            errors++;
            $display("ERROR: renaming went on with an empty free list");
        end
        release_en = 1'b1;
        wait_outputs(0, "renaming with released tags");
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// ==== rename_unit.f ====
+incdir+hw
hw/rename_pkg.sv
hw/fetch_buffer.sv
hw/insn_decoder.sv
hw/phys_tag_freelist.sv
hw/rename_map_table.sv
hw/rename_output_stage.sv
hw/rename_unit.sv
verif/rename_unit_tb.sv
